// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
TOP       ?= tb_gpg_spi
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "simulation FAILED"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: gpg_cmd_sched.sv
`timescale 1ns/100ps

module gpg_cmd_sched import gpg_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  motor_cfg_t motor_i,
  input  led_cfg_t   led_i,
  input  logic       seq_busy_i,  // sequencer still on a frame or in the gap
  output logic       frame_req_o, // one cycle pulse
  output gpg_frame_t frame_o
);

  logic [23:0]               cur    [GPG_NUM_FIELDS]; // fields as seen on the inputs
  logic [23:0]               sent_q [GPG_NUM_FIELDS]; // value last put in a frame
  logic [GPG_NUM_FIELDS-1:0] diff;
  logic [GPG_NUM_FIELDS-1:0] pend_q;
  logic [GPG_NUM_FIELDS-1:0] served;
  logic [3:0]                last_q;  // index served last
  logic [3:0]                cand;
  logic [3:0]                pick_idx;
  logic                      pick_found;
  logic                      issue;

  // widen every field to 24 bits so they can share one compare and one store
  always_comb begin
    cur[F_PWM_LEFT]   = {16'h0, motor_i.pwm_left};
    cur[F_PWM_RGHT]   = {16'h0, motor_i.pwm_rght};
    cur[F_DPS_LIMIT]  = {8'h0, motor_i.dps_limit};
    cur[F_DPS_LEFT]   = {8'h0, motor_i.dps_left};
    cur[F_DPS_RGHT]   = {8'h0, motor_i.dps_rght};
    cur[F_EYE_LEFT]   = led_i.eye_left;
    cur[F_EYE_RGHT]   = led_i.eye_rght;
    cur[F_BLINK_LEFT] = led_i.blink_left;
    cur[F_BLINK_RGHT] = led_i.blink_rght;
  end

  always_comb begin
    for (int i = 0; i < GPG_NUM_FIELDS; i++) begin
      diff[i] = (cur[i] != sent_q[i]);
    end
  end

  // round robin, start searching just after the last served field
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = last_q;
    cand       = last_q;
    for (int k = 1; k <= GPG_NUM_FIELDS; k++) begin
      cand = 4'((int'(last_q) + k) % GPG_NUM_FIELDS);
      if (!pick_found && pend_q[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  // frame_req_o check keeps us from firing twice before seq_busy rises
  assign issue  = pick_found && !seq_busy_i && !frame_req_o;
  assign served = issue ? (GPG_NUM_FIELDS'(1) << pick_idx) : '0;

  function automatic gpg_frame_t build_frame(logic [3:0] idx, logic [23:0] val);
    gpg_frame_t  f;
    logic [15:0] lim;
    f          = '0;
    lim        = (val[15:0] > GPG_DPS_CAP) ? GPG_DPS_CAP : val[15:0];
    f.bytes[0] = GPG_ADDR;
    case (idx)
      F_PWM_LEFT, F_PWM_RGHT: begin
        f.op       = OP_SET_MOTOR_PWM;
        f.len      = 3'd4;
        f.bytes[2] = (idx == F_PWM_LEFT) ? MOTOR_LEFT : MOTOR_RGHT;
        f.bytes[3] = val[7:0]; // already two's complement
      end
      F_DPS_LIMIT: begin
        f.op       = OP_SET_MOTOR_LIMIT;
        f.len      = 3'd5;
        f.bytes[2] = MOTOR_BOTH;  // one limit for both motors
        f.bytes[3] = lim[15:8];
        f.bytes[4] = lim[7:0];
      end
      F_DPS_LEFT, F_DPS_RGHT: begin
        f.op       = OP_SET_MOTOR_DPS;
        f.len      = 3'd5;
        f.bytes[2] = (idx == F_DPS_LEFT) ? MOTOR_LEFT : MOTOR_RGHT;
        f.bytes[3] = val[15:8]; // msb first
        f.bytes[4] = val[7:0];
      end
      default: begin // one of the four leds
        f.op       = OP_SET_LED;
        f.len      = 3'd6;
        case (idx)
          F_EYE_LEFT:   f.bytes[2] = LED_EYE_LEFT;
          F_EYE_RGHT:   f.bytes[2] = LED_EYE_RGHT;
          F_BLINK_LEFT: f.bytes[2] = LED_BLINK_LEFT;
          default:      f.bytes[2] = LED_BLINK_RGHT;
        endcase
        f.bytes[3] = val[23:16]; // r
        f.bytes[4] = val[15:8];  // g
        f.bytes[5] = val[7:0];   // b
      end
    endcase
    f.bytes[1] = f.op;
    return f;
  endfunction

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pend_q      <= '1;   // every field goes out once after reset
      last_q      <= 4'd8; // so the first pick is field 0
      frame_req_o <= 1'b0;
    end else begin
      pend_q      <= (pend_q | diff) & ~served; // later changes fold into one frame
      frame_req_o <= issue;
      if (issue) begin
        last_q <= pick_idx;
      end
    end
  end

  // payload, no reset needed, pending flags cover it
  always_ff @(posedge clk) begin
    if (issue) begin
      sent_q[pick_idx] <= cur[pick_idx];
      frame_o          <= build_frame(pick_idx, cur[pick_idx]);
    end
  end

endmodule

// File: gpg_frame_seq.sv
`timescale 1ns/100ps

module gpg_frame_seq import gpg_pkg::*, spi_pkg::*; #(
  parameter int G_GAP_CYC = 8 // idle clock cycles between frames
) (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       frame_req_i,
  input  gpg_frame_t frame_i,
  input  logic       byte_busy_i,
  input  logic       byte_done_i,
  output logic       byte_start_o,  // one cycle pulse to the byte master
  output logic [7:0] tx_byte_o,
  output logic       spi_ss_n_o,
  output logic       seq_busy_o,
  output logic       frame_start_o, // with ss falling
  output logic       frame_end_o,   // with ss rising
  output gpg_op_e    frame_op_o
);

  localparam int CNT_W     = 16;
  localparam int GUARD_CYC = 2;  // margin over the measured enable period
  localparam int ENA_DEF   = 16; // used until the first byte has been measured

  seq_state_e       state;
  gpg_frame_t       frame_q;
  logic [2:0]       idx;     // byte within the frame
  logic [CNT_W-1:0] wait_cnt;
  logic [CNT_W-1:0] busy_cnt; // length of the byte in flight
  logic [CNT_W-1:0] ena_per;  // estimated enable period in clk cycles
  logic             busy_q;

  assign seq_busy_o = (state != S_IDLE);
  assign tx_byte_o  = frame_q.bytes[idx];
  assign frame_op_o = frame_q.op;

  // a byte spans 16 enables, so busy length / 16 is about one enable period
  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q   <= 1'b0;
      busy_cnt <= '0;
      ena_per  <= CNT_W'(ENA_DEF);
    end else begin
      busy_q <= byte_busy_i;
      if (byte_busy_i) begin
        busy_cnt <= busy_cnt + 1'b1;
      end else if (busy_q) begin // falling edge of busy
        ena_per  <= busy_cnt >> 4;
        busy_cnt <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state         <= S_IDLE;
      spi_ss_n_o    <= 1'b1;
      byte_start_o  <= 1'b0;
      frame_start_o <= 1'b0;
      frame_end_o   <= 1'b0;
      idx           <= '0;
      wait_cnt      <= '0;
    end else begin
      byte_start_o  <= 1'b0; // strobes default low
      frame_start_o <= 1'b0;
      frame_end_o   <= 1'b0;
      case (state)
        S_IDLE: begin
          if (frame_req_i) begin
            spi_ss_n_o    <= 1'b0;
            frame_start_o <= 1'b1;
            idx           <= '0;
            wait_cnt      <= ena_per + CNT_W'(GUARD_CYC);
            state         <= S_SEL;
          end
        end
        S_SEL: begin
          if (wait_cnt == '0) state <= S_BYTE;
          else wait_cnt <= wait_cnt - 1'b1;
        end
        S_BYTE: begin
          if (!byte_busy_i) begin
            byte_start_o <= 1'b1;
            state        <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (byte_done_i) begin
            if (idx == frame_q.len - 3'd1) begin // last byte of the frame
              wait_cnt <= ena_per + CNT_W'(GUARD_CYC);
              state    <= S_DESEL;
            end else begin
              idx   <= idx + 3'd1;
              state <= S_BYTE;
            end
          end
        end
        S_DESEL: begin
          if (wait_cnt == '0) begin
            spi_ss_n_o  <= 1'b1;
            frame_end_o <= 1'b1;
            wait_cnt    <= CNT_W'(G_GAP_CYC - 1);
            state       <= S_GAP;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        S_GAP: begin
          if (wait_cnt == '0) state <= S_IDLE;
          else wait_cnt <= wait_cnt - 1'b1;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // frame payload, loaded on request
  always_ff @(posedge clk) begin
    if (state == S_IDLE && frame_req_i) frame_q <= frame_i;
  end

endmodule

// File: gpg_pkg.sv
package gpg_pkg;

  // command opcodes, second byte of every frame
  typedef enum logic [7:0] {
    OP_SET_MOTOR_PWM   = 8'h11, // signed pwm, one motor
    OP_SET_MOTOR_LIMIT = 8'h12, // dps limit, both motors
    OP_SET_MOTOR_DPS   = 8'h13, // speed in degrees per second, one motor
    OP_SET_LED         = 8'h14  // one rgb led
  } gpg_op_e;

  localparam logic [7:0] GPG_ADDR = 8'h08; // board address, always sent first

  // port byte codes, third byte of every frame
  localparam logic [7:0] MOTOR_LEFT     = 8'h01;
  localparam logic [7:0] MOTOR_RGHT     = 8'h02;
  localparam logic [7:0] MOTOR_BOTH     = 8'h03;
  localparam logic [7:0] LED_EYE_LEFT   = 8'h02;
  localparam logic [7:0] LED_EYE_RGHT   = 8'h01;
  localparam logic [7:0] LED_BLINK_LEFT = 8'h04;
  localparam logic [7:0] LED_BLINK_RGHT = 8'h08;

  localparam int          GPG_NUM_FIELDS = 9;
  localparam int          GPG_FRAME_MAX  = 6;        // led frame is the longest
  localparam logic [15:0] GPG_DPS_CAP    = 16'h7FFF; // motor board takes no more

  // field indices, this is also the round-robin order
  localparam logic [3:0] F_PWM_LEFT   = 4'd0;
  localparam logic [3:0] F_PWM_RGHT   = 4'd1;
  localparam logic [3:0] F_DPS_LIMIT  = 4'd2;
  localparam logic [3:0] F_DPS_LEFT   = 4'd3;
  localparam logic [3:0] F_DPS_RGHT   = 4'd4;
  localparam logic [3:0] F_EYE_LEFT   = 4'd5;
  localparam logic [3:0] F_EYE_RGHT   = 4'd6;
  localparam logic [3:0] F_BLINK_LEFT = 4'd7;
  localparam logic [3:0] F_BLINK_RGHT = 4'd8;

  typedef struct packed {
    logic [7:0]  pwm_left;  // two's complement, -100 to 100
    logic [7:0]  pwm_rght;
    logic [15:0] dps_limit; // 0 means no limit
    logic [15:0] dps_left;
    logic [15:0] dps_rght;
  } motor_cfg_t;

  // each colour is r[23:16] g[15:8] b[7:0]
  typedef struct packed {
    logic [23:0] eye_left;
    logic [23:0] eye_rght;
    logic [23:0] blink_left;
    logic [23:0] blink_rght;
  } led_cfg_t;

  typedef struct packed {
    gpg_op_e                       op;
    logic [2:0]                    len;   // 4 to 6 bytes
    logic [GPG_FRAME_MAX-1:0][7:0] bytes; // bytes[0] goes out first
  } gpg_frame_t;

  typedef struct packed {
    gpg_op_e    op;
    logic [7:0] rx_hi; // second to last miso byte
    logic [7:0] rx_lo; // last miso byte
  } gpg_rsp_t;

endpackage

// File: gpg_rsp_capture.sv
`timescale 1ns/100ps

module gpg_rsp_capture import gpg_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       frame_start_i,
  input  gpg_op_e    frame_op_i,
  input  logic       byte_done_i,
  input  logic [7:0] rx_byte_i,
  input  logic       frame_end_i,
  output gpg_rsp_t   rsp_o,
  output logic       rsp_valid_o  // cycle after frame end
);

  gpg_op_e    op_q;
  logic [7:0] rx_hi_q;
  logic [7:0] rx_lo_q;

  // op and the two byte window, payload only
  always_ff @(posedge clk) begin
    if (frame_start_i) op_q <= frame_op_i;
    if (byte_done_i) begin
      rx_hi_q <= rx_lo_q;
      rx_lo_q <= rx_byte_i;
    end
    if (frame_end_i) begin
      rsp_o.op    <= op_q;
      rsp_o.rx_hi <= rx_hi_q;
      rsp_o.rx_lo <= rx_lo_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) rsp_valid_o <= 1'b0;
    else rsp_valid_o <= frame_end_i;
  end

endmodule

// File: gpg_spi_sva.sv
`timescale 1ns/100ps

module gpg_spi_sva (
  input logic clk,
  input logic rst_i,
  input logic sclk_i,
  input logic mosi_i,
  input logic ss_n_i,
  input logic rsp_valid_i
);

  int unsigned fail_cnt = 0; // failed assertions so far

  // no clock pulses outside a frame
  a_sclk_idle: assert property (@(posedge clk) disable iff (rst_i) ss_n_i |-> !sclk_i)
    else begin
      $error("sclk_o high while spi_ss_n_o is high");
      fail_cnt++;
    end

  // in mode 0 data only moves while sclk is low
  a_mosi_stable: assert property (@(posedge clk) disable iff (rst_i)
    sclk_i |-> $stable(mosi_i))
    else begin
      $error("mosi_o changed while sclk_o was high");
      fail_cnt++;
    end

  // response only in the cycle right after slave select rose
  a_rsp_timing: assert property (@(posedge clk) disable iff (rst_i)
    rsp_valid_i |-> ($past(ss_n_i, 1) && !$past(ss_n_i, 2)))
    else begin
      $error("rsp_valid_o not in the cycle after spi_ss_n_o rose");
      fail_cnt++;
    end

endmodule

bind gpg_spi_top gpg_spi_sva sva0 (
  .clk         (clk),
  .rst_i       (rst_i),
  .sclk_i      (sclk_o),
  .mosi_i      (mosi_o),
  .ss_n_i      (spi_ss_n_o),
  .rsp_valid_i (rsp_valid_o)
);

// File: gpg_spi_top.sv
`timescale 1ns/100ps

module gpg_spi_top import gpg_pkg::*; #(
  parameter int G_CLK_FREQ_MHZ = 12,   // integer mhz, use the pll output if one is used
  parameter int G_SCLK_KHZ     = 1000,
  parameter int G_GAP_CYC      = 8
) (
  input  logic       clk,
  input  logic       rst_i,
  input  motor_cfg_t motor_i,
  input  led_cfg_t   led_i,
  output logic       sclk_o,
  input  logic       miso_i,
  output logic       mosi_o,
  output logic       spi_ss_n_o,  // active low
  output gpg_rsp_t   rsp_o,
  output logic       rsp_valid_o
);

  logic       frame_req;
  gpg_frame_t frame;
  logic       seq_busy;
  logic       byte_start;
  logic [7:0] tx_byte;
  logic       byte_busy;
  logic       byte_done;
  logic [7:0] rx_byte;
  logic       frame_start;
  logic       frame_end;
  gpg_op_e    frame_op;

  // decode
  gpg_cmd_sched i_cmd_sched (
    .clk         (clk),
    .rst_i       (rst_i),
    .motor_i     (motor_i),
    .led_i       (led_i),
    .seq_busy_i  (seq_busy),
    .frame_req_o (frame_req),
    .frame_o     (frame)
  );

  // execute control
  gpg_frame_seq #(.G_GAP_CYC(G_GAP_CYC)) i_frame_seq (
    .clk           (clk),
    .rst_i         (rst_i),
    .frame_req_i   (frame_req),
    .frame_i       (frame),
    .byte_busy_i   (byte_busy),
    .byte_done_i   (byte_done),
    .byte_start_o  (byte_start),
    .tx_byte_o     (tx_byte),
    .spi_ss_n_o    (spi_ss_n_o),
    .seq_busy_o    (seq_busy),
    .frame_start_o (frame_start),
    .frame_end_o   (frame_end),
    .frame_op_o    (frame_op)
  );

  // execute datapath, mode fixed at cpol 0 cpha 0 msb first
  spi_byte_master #(
    .G_CLK_FREQ_MHZ (G_CLK_FREQ_MHZ),
    .G_SCLK_KHZ     (G_SCLK_KHZ)
  ) i_spi_master (
    .clk          (clk),
    .rst_i        (rst_i),
    .byte_start_i (byte_start),
    .tx_byte_i    (tx_byte),
    .miso_i       (miso_i),
    .sclk_o       (sclk_o),
    .mosi_o       (mosi_o),
    .byte_busy_o  (byte_busy),
    .byte_done_o  (byte_done),
    .rx_byte_o    (rx_byte)
  );

  // result
  gpg_rsp_capture i_rsp_capture (
    .clk           (clk),
    .rst_i         (rst_i),
    .frame_start_i (frame_start),
    .frame_op_i    (frame_op),
    .byte_done_i   (byte_done),
    .rx_byte_i     (rx_byte),
    .frame_end_i   (frame_end),
    .rsp_o         (rsp_o),
    .rsp_valid_o   (rsp_valid_o)
  );

endmodule

// File: sim.f
gpg_pkg.sv
spi_pkg.sv
gpg_cmd_sched.sv
gpg_frame_seq.sv
spi_byte_master.sv
gpg_rsp_capture.sv
gpg_spi_top.sv
gpg_spi_sva.sv
tb_clk_gen.sv
tb_gpg_spi.sv

// File: spi_byte_master.sv
`timescale 1ns/100ps

module spi_byte_master import spi_pkg::*; #(
  parameter int G_CLK_FREQ_MHZ = 12,   // system clock, integer mhz
  parameter int G_SCLK_KHZ     = 1000  // target sclk
) (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       byte_start_i,
  input  logic [7:0] tx_byte_i,
  input  logic       miso_i,
  output logic       sclk_o,
  output logic       mosi_o,
  output logic       byte_busy_o,
  output logic       byte_done_o, // one cycle after the 8th falling edge
  output logic [7:0] rx_byte_o
);

  // enable rate is twice sclk, one tick per edge
  localparam int DIV_RAW = G_CLK_FREQ_MHZ * 1000 / (2 * G_SCLK_KHZ);
  localparam int DIV     = (DIV_RAW < 1) ? 1 : DIV_RAW;
  localparam int DIV_W   = (DIV > 1) ? $clog2(DIV) : 1;

  spi_state_e       state;
  logic [DIV_W-1:0] div_cnt;
  logic             ena_2clk;
  logic [7:0]       tx_sr;
  logic [7:0]       rx_sr;
  logic [2:0]       bit_cnt;
  spi_rx_t          rx_q;

  assign ena_2clk    = (div_cnt == DIV_W'(DIV - 1));
  assign byte_busy_o = (state != IDLE);
  assign byte_done_o = rx_q.valid;
  assign rx_byte_o   = rx_q.data;

  // free running divider, so start to done latency depends on phase
  always_ff @(posedge clk) begin
    if (rst_i || ena_2clk) div_cnt <= '0;
    else div_cnt <= div_cnt + 1'b1;
  end

  // mode 0, msb first
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state   <= IDLE;
      sclk_o  <= 1'b0;
      mosi_o  <= 1'b0;
      bit_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (byte_start_i) begin
            mosi_o  <= tx_byte_i[7]; // first bit ahead of the first rising edge
            bit_cnt <= '0;
            state   <= SHIFT;
          end
        end
        SHIFT: begin
          if (ena_2clk) begin
            sclk_o <= ~sclk_o;
            if (sclk_o) begin // falling edge, next bit out
              mosi_o  <= tx_sr[6];
              bit_cnt <= bit_cnt + 3'd1;
              if (bit_cnt == 3'd7) state <= DONE;
            end
          end
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // shift registers
  always_ff @(posedge clk) begin
    if (state == IDLE && byte_start_i) begin
      tx_sr <= tx_byte_i;
    end else if (state == SHIFT && ena_2clk) begin
      if (!sclk_o) rx_sr <= {rx_sr[6:0], miso_i}; // sample on rising edge
      else tx_sr <= {tx_sr[6:0], 1'b0};           // shift on falling edge
    end
  end

  // hand the byte over, data needs no reset
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_q.valid <= 1'b0;
    end else begin
      rx_q.valid <= (state == DONE);
      if (state == DONE) rx_q.data <= rx_sr;
    end
  end

endmodule

// File: spi_pkg.sv
package spi_pkg;

  // byte shifter states
  typedef enum logic [1:0] {
    IDLE,  // sclk parked low
    SHIFT, // 16 half periods
    DONE   // one cycle, hands the byte over
  } spi_state_e;

  // frame sequencer states
  typedef enum logic [2:0] {
    S_IDLE,  // waiting for a frame request
    S_SEL,   // ss low, setup time before first byte
    S_BYTE,  // issue next byte start
    S_WAIT,  // byte on the wire
    S_DESEL, // hold time before ss goes high
    S_GAP    // inter-frame gap
  } seq_state_e;

  typedef struct packed {
    logic       valid; // one cycle strobe
    logic [7:0] data;
  } spi_rx_t;

endpackage

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 10,
  parameter int RST_CYC   = 2  // clock cycles with reset high
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    repeat (RST_CYC) @(posedge clk_o);
    rst_o <= 1'b0; // released on a rising edge like any other input
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// File: tb_gpg_spi.sv
`timescale 1ns/100ps

module tb_gpg_spi import gpg_pkg::*; ();

  localparam int NUM_FIXED   = 5;
  localparam int NUM_ROWS    = NUM_FIXED + 6; // the rest come from the lcg
  localparam int IDLE_CYC    = 200;           // ss high this long ends a row
  localparam int FRAME_CYC   = GPG_FRAME_MAX * 16 * 6; // bytes x enables x clk per enable
  localparam int TIMEOUT_CYC = (NUM_ROWS + 1) * (GPG_NUM_FIELDS * FRAME_CYC * 2 + 2 * IDLE_CYC);

  typedef struct packed {
    motor_cfg_t motor;
    led_cfg_t   led;
    logic       fold; // blink_rght changes several times during another frame
  } row_t;

  logic       clk;
  logic       rst_i;
  motor_cfg_t motor_i;
  led_cfg_t   led_i;
  logic       miso_i;
  logic       sclk_o;
  logic       mosi_o;
  logic       spi_ss_n_o;
  gpg_rsp_t   rsp_o;
  logic       rsp_valid_o;

  row_t        rows [NUM_ROWS];
  logic [31:0] lcg_state = 32'd41;

  // reference model state
  logic [23:0]               ref_sent [GPG_NUM_FIELDS];
  logic [GPG_NUM_FIELDS-1:0] ref_pend;
  int                        ref_last;
  gpg_frame_t                exp_frames [$];
  gpg_rsp_t                  exp_rsps [$];

  // slave model state
  gpg_frame_t rx_frame;          // frame as seen on mosi
  int         rx_cnt;            // bits sampled in this frame
  int         fall_cnt;          // falling sclk edges in this frame
  logic [7:0] miso_byte;         // byte being returned
  logic [7:0] prev_op = 8'h00;   // op of the previous frame, none before the first
  logic       ss_q    = 1'b1;
  logic       sclk_q  = 1'b0;
  int         cyc     = 0;

  tb_clk_gen clk_gen0 (
    .clk_o (clk),
    .rst_o (rst_i)
  );

  gpg_spi_top #(
    .G_CLK_FREQ_MHZ (12),
    .G_SCLK_KHZ     (1000)
  ) dut0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .motor_i     (motor_i),
    .led_i       (led_i),
    .sclk_o      (sclk_o),
    .miso_i      (miso_i),
    .mosi_o      (mosi_o),
    .spi_ss_n_o  (spi_ss_n_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic coin();
    logic [31:0] r;
    r = lcg_next();
    return r[30]; // low bits of an lcg repeat too soon
  endfunction

  function automatic logic [7:0] rand_pwm();
    logic [31:0] r;
    r = lcg_next();
    return 8'(int'((r >> 8) % 201) - 100); // -100 to 100
  endfunction

  // field i of the inputs, index order as on the board
  function automatic logic [23:0] field_val(int i, motor_cfg_t m, led_cfg_t l);
    case (i)
      0:       return {16'h0, m.pwm_left};
      1:       return {16'h0, m.pwm_rght};
      2:       return {8'h0, m.dps_limit};
      3:       return {8'h0, m.dps_left};
      4:       return {8'h0, m.dps_rght};
      5:       return l.eye_left;
      6:       return l.eye_rght;
      7:       return l.blink_left;
      default: return l.blink_rght;
    endcase
  endfunction

  // frame the board expects for field i with value v
  function automatic gpg_frame_t exp_frame(int i, logic [23:0] v);
    gpg_frame_t f;
    f          = '0;
    f.bytes[0] = 8'h08;
    if (i <= 1) begin
      f.op       = OP_SET_MOTOR_PWM;
      f.len      = 3'd4;
      f.bytes[2] = (i == 0) ? 8'h01 : 8'h02;
      f.bytes[3] = v[7:0]; // two's complement as is
    end else if (i <= 4) begin
      f.op       = (i == 2) ? OP_SET_MOTOR_LIMIT : OP_SET_MOTOR_DPS;
      f.len      = 3'd5;
      f.bytes[2] = (i == 2) ? 8'h03 : (i == 3) ? 8'h01 : 8'h02;
      if (i == 2 && v[15:0] > 16'h7FFF) v[15:0] = 16'h7FFF; // limit capped
      f.bytes[3] = v[15:8];
      f.bytes[4] = v[7:0];
    end else begin
      f.op       = OP_SET_LED;
      f.len      = 3'd6;
      f.bytes[2] = (i == 5) ? 8'h02 : (i == 6) ? 8'h01 : (i == 7) ? 8'h04 : 8'h08;
      f.bytes[3] = v[23:16];
      f.bytes[4] = v[15:8];
      f.bytes[5] = v[7:0];
    end
    f.bytes[1] = f.op;
    return f;
  endfunction

  // slave reply for byte k
  function automatic logic [7:0] ret_byte(int k, logic [7:0] op);
    return 8'(8'hA0 + k) ^ op;
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_frame(gpg_frame_t got, gpg_frame_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch mosi_o frame got %h expected %h", got, exp));
    end
  endtask

  task automatic check_rsp(gpg_rsp_t got, gpg_rsp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch rsp_o got %h expected %h", got, exp));
    end
  endtask

  // round robin from the last served field, value as now on the inputs
  task automatic pick_expected();
    int          idx;
    int          c;
    logic [23:0] v;
    gpg_frame_t  f;
    idx = -1;
    for (int k = 1; k <= GPG_NUM_FIELDS; k++) begin
      c = (ref_last + k) % GPG_NUM_FIELDS;
      if (idx < 0 && ref_pend[c]) idx = c;
    end
    if (idx < 0) begin
      abort_run("slave select fell with no field pending");
    end else begin
      v             = field_val(idx, motor_i, led_i);
      f             = exp_frame(idx, v);
      ref_sent[idx] = v;
      ref_pend[idx] = 1'b0;
      ref_last      = idx;
      exp_frames.push_back(f);
      exp_rsps.push_back({f.op, ret_byte(f.len - 2, f.op), ret_byte(f.len - 1, f.op)});
    end
  endtask

  // spi slave, reference model and checks in one process
  always @(posedge clk) begin
    if (!rst_i) begin
      for (int i = 0; i < GPG_NUM_FIELDS; i++) begin
        if (field_val(i, motor_i, led_i) != ref_sent[i]) ref_pend[i] = 1'b1;
      end
      if (!spi_ss_n_o && ss_q) begin // frame start
        pick_expected();
        rx_cnt    = 0;
        fall_cnt  = 0;
        rx_frame  = '0;
        miso_byte = ret_byte(0, prev_op);
        miso_i   <= miso_byte[7];
      end else if (!spi_ss_n_o && sclk_o && !sclk_q) begin // rising edge seen
        if (rx_cnt >= 8 * GPG_FRAME_MAX) abort_run("frame longer than six bytes");
        else rx_frame.bytes[rx_cnt / 8][7 - rx_cnt % 8] = mosi_o;
        rx_cnt++;
      end else if (!spi_ss_n_o && !sclk_o && sclk_q) begin // falling edge seen
        fall_cnt++;
        // the op only arrives as byte 1, so bytes 0 and 1 use the previous one
        if (fall_cnt % 8 == 0) begin
          miso_byte = ret_byte(fall_cnt / 8, (fall_cnt >= 16) ? rx_frame.bytes[1] : prev_op);
        end
        miso_i <= miso_byte[7 - fall_cnt % 8];
      end else if (spi_ss_n_o && !ss_q) begin // frame end
        if (rx_cnt % 8 != 0 || rx_cnt < 32) begin
          abort_run($sformatf("frame ended after %0d bits", rx_cnt));
        end else if (exp_frames.size() == 0) begin
          abort_run("frame received with none expected");
        end else begin
          rx_frame.len = 3'(rx_cnt / 8);
          rx_frame.op  = gpg_op_e'(rx_frame.bytes[1]);
          prev_op      = rx_frame.bytes[1];
          check_frame(rx_frame, exp_frames.pop_front());
        end
      end
      if (rsp_valid_o) begin
        if (exp_rsps.size() == 0) abort_run("response with no frame behind it");
        else check_rsp(rsp_o, exp_rsps.pop_front());
      end
    end
    ss_q   = spi_ss_n_o;
    sclk_q = sclk_o;
  end

  // timeout and assertion watch
  always @(posedge clk) begin
    cyc++;
    if (cyc >= TIMEOUT_CYC) begin
      abort_run($sformatf("Timeout after %0d cycles", cyc));
    end else if (dut0.sva0.fail_cnt != 0) begin
      abort_run("an SPI pin assertion failed");
    end
  end

  task automatic build_table();
    rows[0].motor = {8'h9C, 8'h64, 16'h9000, 16'h0123, 16'hFF38}; // -100, 100, limit over cap
    rows[0].led   = {24'h102030, 24'h405060, 24'hFF0000, 24'h0000FF};
    rows[0].fold  = 1'b0;
    rows[1]                 = rows[0];
    rows[1].motor.pwm_rght  = 8'hCE; // -50
    rows[1].led.eye_rght    = 24'h00FF00;
    rows[2]                 = rows[1];
    rows[2].motor.dps_limit = 16'hFFFF;
    rows[2].led.blink_left  = 24'h123456;
    rows[3]                 = rows[2];
    rows[3].motor.pwm_left  = 8'hFF;
    rows[3].motor.dps_rght  = 16'h7FFF;
    rows[3].led.eye_left    = 24'hABCDEF;
    rows[4]                 = rows[3];
    rows[4].led.eye_left    = 24'h0F0F0F; // long frame on the wire
    rows[4].led.blink_rght  = 24'h55AA55; // final value after the changes
    rows[4].fold            = 1'b1;
    for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
      rows[r]      = rows[r - 1];
      rows[r].fold = 1'b0;
      if (coin()) rows[r].motor.pwm_left = rand_pwm();
      if (coin()) rows[r].motor.pwm_rght = rand_pwm();
      if (coin()) rows[r].motor.dps_limit = 16'(lcg_next() >> 8);
      if (coin()) rows[r].motor.dps_left = 16'(lcg_next() >> 8);
      if (coin()) rows[r].motor.dps_rght = 16'(lcg_next() >> 8);
      if (coin()) rows[r].led.eye_left = 24'(lcg_next() >> 8);
      if (coin()) rows[r].led.eye_rght = 24'(lcg_next() >> 8);
      if (coin()) rows[r].led.blink_left = 24'(lcg_next() >> 8);
      if (coin()) rows[r].led.blink_rght = 24'(lcg_next() >> 8);
    end
  endtask

  task automatic wait_idle();
    int hi_cnt;
    hi_cnt = 0;
    while (hi_cnt < IDLE_CYC) begin
      @(posedge clk);
      hi_cnt = spi_ss_n_o ? hi_cnt + 1 : 0;
    end
    if (ref_pend != '0 || exp_frames.size() != 0 || exp_rsps.size() != 0) begin
      abort_run("bus went idle with frames or responses still missing");
    end
  endtask

  task automatic apply_row(row_t row);
    led_cfg_t first_led;
    first_led = row.led;
    if (row.fold) first_led.blink_rght = led_i.blink_rght; // held back until a frame runs
    @(posedge clk);
    motor_i <= row.motor;
    led_i   <= first_led;
    if (row.fold) begin
      while (spi_ss_n_o) @(posedge clk);
      for (int n = 0; n < 3; n++) begin
        repeat (40) @(posedge clk);
        led_i.blink_rght <= (n == 2) ? row.led.blink_rght : 24'(lcg_next() >> 8);
      end
    end
    wait_idle();
  endtask

  initial begin
    build_table();
    motor_i  = rows[0].motor;
    led_i    = rows[0].led;
    miso_i   = 1'b0;
    ref_pend = '1; // every field goes out once after reset
    ref_last = GPG_NUM_FIELDS - 1;
    for (int i = 0; i < GPG_NUM_FIELDS; i++) begin
      ref_sent[i] = '0;
    end
    @(negedge rst_i);
    wait_idle(); // nine frames in field order
    for (int r = 1; r < NUM_ROWS; r++) begin
      apply_row(rows[r]);
    end
    if (dut0.sva0.fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
